// ==== common/posit_cfg.svh ====
`ifndef POSIT_CFG_SVH
`define POSIT_CFG_SVH

// posit word width and exponent size.
`define POSIT_N 16
`define POSIT_ES 1

// number of parallel multiplier lanes.
`define LANES 4

// total exponent of a product, signed, with headroom for the carry.
`define TE_SIZE ($clog2(`POSIT_N) + `POSIT_ES + 3)

// regime value before clamping, signed.
`define K_SIZE (`TE_SIZE - `POSIT_ES)

// fraction including the hidden bit.
`define MANT_SIZE (`POSIT_N - 2 - `POSIT_ES)

// regime length, run plus terminator.
`define REG_LEN_SIZE ($clog2(`POSIT_N) + 1)

`endif

// ==== common/posit_pkg.sv ====
`default_nettype none

`include "posit_cfg.svh"

package posit_pkg;

    typedef logic [`POSIT_N-1:0] posit_t;

    // one operand after decoding.
    typedef struct packed {
        logic                        sign;
        logic                        zero;
        logic                        nar;
        logic signed [`TE_SIZE-1:0]  scale;  // k * 2^es + exponent.
        logic [`MANT_SIZE-1:0]       frac;   // hidden bit at the top.
    } decoded_t;

    // product fields ready for encoding.
    typedef struct packed {
        logic signed [`K_SIZE-1:0]   k;      // clamped regime value.
        logic [`POSIT_ES-1:0]        exp;    // kept bits left aligned.
        logic [`MANT_SIZE-1:0]       frac;   // kept bits right aligned.
        logic                        round;
        logic                        sticky;
        logic                        oob;    // regime was clamped.
    } fields_t;

    localparam posit_t maxpos = {1'b0, {(`POSIT_N-1){1'b1}}};
    localparam posit_t nar    = {1'b1, {(`POSIT_N-1){1'b0}}};

endpackage

`default_nettype wire

// ==== common/lane_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface lane_if;

    // operand side.
    logic              valid;
    posit_pkg::posit_t a;
    posit_pkg::posit_t b;

    // result side.
    logic              res_valid;
    posit_pkg::posit_t result;
    logic              sat;

    modport feed (
        output valid,
        output a,
        output b
    );

    modport lane (
        input  valid,
        input  a,
        input  b,
        output res_valid,
        output result,
        output sat
    );

    modport drain (
        input  res_valid,
        input  result,
        input  sat
    );

endinterface

`default_nettype wire

// ==== hw/operand_scatter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module operand_scatter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [`LANES*`POSIT_N-1:0]    a,
    input  logic [`LANES*`POSIT_N-1:0]    b,
    lane_if.feed                          lanes [`LANES]
);

    localparam int N = `POSIT_N;

    logic                       valid_q;
    logic [`LANES*`POSIT_N-1:0] a_q;
    logic [`LANES*`POSIT_N-1:0] b_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // operand vectors only move on a strobe.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q <= a;
            b_q <= b;
        end
    end

    genvar i;
    generate
        for (i = 0; i < `LANES; i++) begin : g_feed
            assign lanes[i].valid = valid_q;
            assign lanes[i].a     = a_q[i*N +: N];  // lane i slice.
            assign lanes[i].b     = b_q[i*N +: N];
        end
    endgenerate

    a_known_operands: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_q |-> !$isunknown({a_q, b_q})
    ) else $error("lane operands unknown while valid");

endmodule

`default_nettype wire

// ==== posit_lane/posit_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module posit_decode (
    input  posit_pkg::posit_t   p,
    output posit_pkg::decoded_t d
);

    localparam int N  = `POSIT_N;
    localparam int ES = `POSIT_ES;
    localparam int TS = `TE_SIZE;
    localparam int BW = N - 1;
    localparam int FW = `MANT_SIZE - 1;

    logic [N-1:0]          mag;
    logic [BW-1:0]         body;
    logic [BW-1:0]         rest;
    logic signed [TS-1:0]  run;
    logic signed [TS-1:0]  k;
    logic [ES-1:0]         exp_bits;
    logic [FW-1:0]         frac_bits;

    assign mag  = p[N-1] ? -p : p;  // negative words decode from magnitude.
    assign body = mag[BW-1:0];

    // length of the leading run of identical bits.
    always_comb begin : count_run
        logic done;
        done = 1'b0;
        run  = '0;
        for (int i = BW - 1; i >= 0; i--) begin
            if (!done && (body[i] == body[BW-1])) begin
                run = run + 1'b1;
            end else begin
                done = 1'b1;
            end
        end
    end

    assign k = body[BW-1] ? (run - 1) : -run;  // ones give k >= 0.

    // drop the run and its terminator.
    assign rest      = body << (run + 1);
    assign exp_bits  = rest[BW-1 -: ES];
    assign frac_bits = rest[BW-1-ES -: FW];

    assign d = '{
        sign:  p[N-1],
        zero:  (p == '0),
        nar:   (p == posit_pkg::nar),
        scale: (k <<< ES) + TS'(exp_bits),
        frac:  {1'b1, frac_bits}
    };

endmodule

`default_nettype wire

// ==== posit_lane/shift_fields.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module shift_fields (
    input  logic [2*`MANT_SIZE-1:0]      mant,
    input  logic signed [`TE_SIZE-1:0]   total_exp,
    input  logic [1:0]                   mant_non_fractional_size,
    output posit_pkg::fields_t           f
);

    localparam int N   = `POSIT_N;
    localparam int ES  = `POSIT_ES;
    localparam int KS  = `K_SIZE;
    localparam int MS  = `MANT_SIZE;
    localparam int RLS = `REG_LEN_SIZE;
    localparam int MW  = 2 * `MANT_SIZE;
    localparam int SW  = ES + MW;

    localparam logic signed [KS-1:0] K_MAX = KS'(N - 2);

    logic signed [KS-1:0] k_unpacked;
    logic signed [KS-1:0] regime_k;
    logic [ES-1:0]        exp_unpacked;
    logic [ES-1:0]        exp_field;
    logic [RLS-1:0]       reg_len;
    logic [RLS-1:0]       avail;
    logic [RLS-1:0]       es_len;
    logic [RLS-1:0]       mant_len;
    logic [MW-1:0]        frac_aligned;
    logic [MS-1:0]        frac_down;
    logic [SW-1:0]        dropped;

    // scale splits into useed power and exponent.
    assign k_unpacked   = KS'(total_exp >>> ES);
    assign exp_unpacked = total_exp[ES-1:0];

    assign regime_k = (k_unpacked > K_MAX)  ? K_MAX :
                      (k_unpacked < -K_MAX) ? -K_MAX : k_unpacked;

    // run plus terminator.
    assign reg_len = (regime_k >= 0) ? RLS'(regime_k + 2) : RLS'(1 - regime_k);

    // bits left after sign and regime.
    assign avail    = (reg_len >= RLS'(N - 1)) ? '0 : RLS'(N - 1) - reg_len;
    assign es_len   = (avail < RLS'(ES)) ? avail : RLS'(ES);
    assign mant_len = avail - es_len;

    // exponent keeps its top bits only.
    assign exp_field = (exp_unpacked >> (RLS'(ES) - es_len)) << (RLS'(ES) - es_len);

    // strip the integer part so the fraction is left aligned.
    assign frac_aligned = mant << (3 - mant_non_fractional_size);
    assign frac_down    = MS'(frac_aligned >> (MW - int'(mant_len)));

    // everything below the kept bits feeds rounding.
    assign dropped = {exp_unpacked, frac_aligned} << avail;

    assign f = '{
        k:      regime_k,
        exp:    exp_field,
        frac:   frac_down,
        round:  dropped[SW-1],
        sticky: |dropped[SW-2:0],
        oob:    (k_unpacked != regime_k)
    };

endmodule

`default_nettype wire

// ==== posit_lane/posit_encode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module posit_encode (
    input  posit_pkg::fields_t f,
    input  logic               sign,
    output posit_pkg::posit_t  p
);

    localparam int N   = `POSIT_N;
    localparam int ES  = `POSIT_ES;
    localparam int RLS = `REG_LEN_SIZE;
    localparam int BW  = N - 1;

    logic [RLS-1:0]        reg_len;
    logic signed [RLS:0]   mant_len;
    logic [BW-1:0]         regime;
    logic [BW-1:0]         exp_part;
    logic [BW-1:0]         body;
    logic [BW-1:0]         rounded;
    logic                  round_up;
    posit_pkg::posit_t     mag;

    assign reg_len  = ($signed(f.k) >= 0) ? RLS'($signed(f.k) + 2) : RLS'(1 - $signed(f.k));
    assign mant_len = (RLS+1)'(N - 1 - ES - int'(reg_len));  // negative when es is cut.

    // run of ones with a zero terminator, or zeros ended by a one.
    always_comb begin
        if ($signed(f.k) >= 0) begin
            regime = ~({BW{1'b1}} >> ($signed(f.k) + 1));
        end else begin
            regime = BW'(1) << (N - 2 + $signed(f.k));
        end
    end

    assign exp_part = (mant_len >= 0) ? (BW'(f.exp) << mant_len) :
                                        (BW'(f.exp) >> (-mant_len));

    assign body = regime | exp_part | BW'(f.frac);

    // nearest even, frozen at maxpos; the regime always carries a one,
    // so a body can only reach zero by wrapping past maxpos.
    assign round_up = f.round && (f.sticky || body[0]) && !f.oob &&
                      ({1'b0, body} != posit_pkg::maxpos);
    assign rounded  = body + BW'(round_up);

    assign mag = {1'b0, rounded};
    assign p   = sign ? -mag : mag;  // two's complement for negatives.

endmodule

`default_nettype wire

// ==== posit_lane/posit_mul_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module posit_mul_lane (
    input  logic clk,
    input  logic rst_n,
    lane_if.lane port
);

    localparam int MW = 2 * `MANT_SIZE;

    posit_pkg::decoded_t        da;
    posit_pkg::decoded_t        db;
    posit_pkg::fields_t         fields;
    posit_pkg::posit_t          enc;
    logic [MW-1:0]              prod;
    logic [MW-1:0]              prod_q;
    logic signed [`TE_SIZE-1:0] exp_q;
    logic [1:0]                 nfs;
    logic                       valid_q;
    logic                       sign_q;
    logic                       nar_q;
    logic                       zero_q;
    logic                       res_valid_q;
    posit_pkg::posit_t          result_q;
    logic                       sat_q;

    posit_decode u_dec_a (.p(port.a), .d(da));
    posit_decode u_dec_b (.p(port.b), .d(db));

    assign prod = da.frac * db.frac;  // in [1, 4).

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            valid_q     <= port.valid;
            res_valid_q <= valid_q;
        end
    end

    // stage one.
    always_ff @(posedge clk) begin
        if (port.valid) begin
            prod_q <= prod;
            exp_q  <= da.scale + db.scale + `TE_SIZE'(prod[MW-1]);  // carry renormalizes.
            sign_q <= da.sign ^ db.sign;
            nar_q  <= da.nar | db.nar;
            zero_q <= da.zero | db.zero;
        end
    end

    assign nfs = {prod_q[MW-1], ~prod_q[MW-1]};  // two integer bits or one.

    shift_fields u_shift (
        .mant                     (prod_q),
        .total_exp                (exp_q),
        .mant_non_fractional_size (nfs),
        .f                        (fields)
    );

    posit_encode u_enc (.f(fields), .sign(sign_q), .p(enc));

    // stage two. nar wins over zero.
    always_ff @(posedge clk) begin
        if (valid_q) begin
            result_q <= nar_q ? posit_pkg::nar : (zero_q ? '0 : enc);
            sat_q    <= !nar_q && !zero_q && fields.oob;
        end
    end

    assign port.res_valid = res_valid_q;
    assign port.result    = result_q;
    assign port.sat       = sat_q;

    a_sat_not_special: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid_q && sat_q) |-> (result_q != posit_pkg::nar) && (result_q != '0)
    ) else $error("saturation flagged on a zero or NaR result");

endmodule

`default_nettype wire

// ==== hw/result_gather.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module result_gather (
    input  logic                          clk,
    input  logic                          rst_n,
    lane_if.drain                         lanes [`LANES],
    output logic                          out_valid,
    output logic [`LANES*`POSIT_N-1:0]    result,
    output logic [`LANES-1:0]             sat
);

    localparam int N = `POSIT_N;

    logic [`LANES-1:0] lane_valid;
    logic [`LANES-1:0] lane_sat;
    posit_pkg::posit_t lane_res [`LANES];

    genvar i;
    generate
        for (i = 0; i < `LANES; i++) begin : g_drain
            assign lane_valid[i] = lanes[i].res_valid;
            assign lane_res[i]   = lanes[i].result;
            assign lane_sat[i]   = lanes[i].sat;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= lane_valid[0];  // lanes run in lockstep.
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `LANES; j++) begin
            if (lane_valid[j]) begin
                result[j*N +: N] <= lane_res[j];
                sat[j]           <= lane_sat[j];
            end
        end
    end

    a_lanes_agree: assert property (
        @(posedge clk) disable iff (!rst_n)
        (lane_valid == '0) || (&lane_valid)
    ) else $error("lane result strobes out of step");

endmodule

`default_nettype wire

// ==== hw/posit_mul_array.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module posit_mul_array (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [`LANES*`POSIT_N-1:0]    a,
    input  logic [`LANES*`POSIT_N-1:0]    b,
    output logic                          out_valid,
    output logic [`LANES*`POSIT_N-1:0]    result,
    output logic [`LANES-1:0]             sat
);

    lane_if lane_bus [`LANES] ();

    operand_scatter u_scatter (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .lanes    (lane_bus)
    );

    // identical lanes, one per operand pair.
    genvar i;
    generate
        for (i = 0; i < `LANES; i++) begin : g_lane
            posit_mul_lane u_lane (
                .clk   (clk),
                .rst_n (rst_n),
                .port  (lane_bus[i])
            );
        end
    endgenerate

    result_gather u_gather (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes     (lane_bus),
        .out_valid (out_valid),
        .result    (result),
        .sat       (sat)
    );

endmodule

`default_nettype wire

// ==== verification/tb_posit_mul_array.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "posit_cfg.svh"

module tb_posit_mul_array;

    localparam int N          = `POSIT_N;
    localparam int L          = `LANES;
    localparam int NROWS      = 8;
    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 8;
    localparam int LATENCY    = 4;   // drive cycle to out_valid cycle.
    localparam int WAIT_LIMIT = 20;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    logic [L*N-1:0] a;
    logic [L*N-1:0] b;
    logic           out_valid;
    logic [L*N-1:0] result;
    logic [L-1:0]   sat;

    logic [L*N-1:0] tab_a   [NROWS];
    logic [L*N-1:0] tab_b   [NROWS];
    logic [L*N-1:0] tab_res [NROWS];
    logic [L-1:0]   tab_sat [NROWS];

    logic [L*N-1:0] exp_res_q [$];
    logic [L-1:0]   exp_sat_q [$];
    int             exp_cyc_q [$];

    int cyc = 0;
    int errors;
    int checks;

    posit_mul_array u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .sat       (sat)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;  // cycle count for latency.

    task automatic check_value(input string name, input logic [L*N-1:0] got,
                               input logic [L*N-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic set_lane(input int row, input int lane, input logic [N-1:0] pa,
                            input logic [N-1:0] pb, input logic [N-1:0] pr, input logic ps);
        tab_a[row][lane*N +: N]   = pa;
        tab_b[row][lane*N +: N]   = pb;
        tab_res[row][lane*N +: N] = pr;
        tab_sat[row][lane]        = ps;
    endtask

    // expected products worked out by hand for posit<16,1>.
    task automatic load_table();
        set_lane(0, 0, 16'h4000, 16'h4000, 16'h4000, 1'b0);  // 1 x 1.
        set_lane(0, 1, 16'h5000, 16'h5000, 16'h6000, 1'b0);  // 2 x 2.
        set_lane(0, 2, 16'h5000, 16'h3000, 16'h4000, 1'b0);  // 2 x 0.5.
        set_lane(0, 3, 16'hC000, 16'h5000, 16'hB000, 1'b0);  // -1 x 2.
        set_lane(1, 0, 16'h4800, 16'h4800, 16'h5200, 1'b0);  // 1.5 x 1.5, carry.
        set_lane(1, 1, 16'h6000, 16'h6000, 16'h7000, 1'b0);  // 4 x 4.
        set_lane(1, 2, 16'h2000, 16'h2000, 16'h1000, 1'b0);  // 0.25 x 0.25.
        set_lane(1, 3, 16'hD000, 16'hD000, 16'h2000, 1'b0);  // -0.5 x -0.5.
        set_lane(2, 0, 16'h0000, 16'h4000, 16'h0000, 1'b0);  // zero.
        set_lane(2, 1, 16'h8000, 16'h4000, 16'h8000, 1'b0);  // nar.
        set_lane(2, 2, 16'h8000, 16'h0000, 16'h8000, 1'b0);  // nar beats zero.
        set_lane(2, 3, 16'h7FFF, 16'h0000, 16'h0000, 1'b0);
        set_lane(3, 0, 16'h7FFF, 16'h7FFF, 16'h7FFF, 1'b1);  // maxpos squared.
        set_lane(3, 1, 16'h0001, 16'h0001, 16'h0001, 1'b1);  // minpos squared.
        set_lane(3, 2, 16'h7FFF, 16'h4000, 16'h7FFF, 1'b0);  // maxpos x 1, in range.
        set_lane(3, 3, 16'h8001, 16'h7FFF, 16'h8001, 1'b1);  // -maxpos x maxpos.
        set_lane(4, 0, 16'h4001, 16'h4001, 16'h4002, 1'b0);  // below half.
        set_lane(4, 1, 16'h4C00, 16'h4001, 16'h4C02, 1'b0);  // above half.
        set_lane(4, 2, 16'h4001, 16'h4800, 16'h4802, 1'b0);  // tie, odd goes up.
        set_lane(4, 3, 16'h4003, 16'h4800, 16'h4804, 1'b0);  // tie, even stays.
        set_lane(5, 0, 16'hB400, 16'h4001, 16'hB3FE, 1'b0);  // negative, above half.
        set_lane(5, 1, 16'h4800, 16'h4803, 16'h5202, 1'b0);  // carry, below half.
        set_lane(5, 2, 16'h6000, 16'h0001, 16'h0002, 1'b0);
        set_lane(5, 3, 16'h0001, 16'h4000, 16'h0001, 1'b0);
        set_lane(6, 0, 16'h7FFF, 16'h6000, 16'h7FFF, 1'b1);  // past maxpos.
        set_lane(6, 1, 16'h0001, 16'h2000, 16'h0001, 1'b1);  // below minpos.
        set_lane(6, 2, 16'h3000, 16'h3000, 16'h2000, 1'b0);
        set_lane(6, 3, 16'hC000, 16'hC000, 16'h4000, 1'b0);
        set_lane(7, 0, 16'hC000, 16'h4001, 16'hBFFF, 1'b0);
        set_lane(7, 1, 16'h4C00, 16'hBFFD, 16'hB3FB, 1'b0);  // negative, below half.
        set_lane(7, 2, 16'hB800, 16'hB800, 16'h5200, 1'b0);
        set_lane(7, 3, 16'h4000, 16'h8001, 16'h8001, 1'b0);
    endtask

    task automatic drive_rows();
        int gap;
        for (int r = 0; r < NROWS; r++) begin
            gap = ($urandom % 2 == 0) ? 0 : ($urandom % 3) + 1;  // idle cycles before row.
            for (int g = 0; g < gap; g++) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            @(negedge clk);
            in_valid = 1'b1;
            a        = tab_a[r];
            b        = tab_b[r];
            exp_res_q.push_back(tab_res[r]);
            exp_sat_q.push_back(tab_sat[r]);
            exp_cyc_q.push_back(cyc);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_results();
        int             waited;
        bit             lost;
        logic [L*N-1:0] exp_res;
        logic [L-1:0]   exp_sat;
        int             sent;
        lost = 1'b0;
        for (int r = 0; r < NROWS && !lost; r++) begin
            waited = 0;
            @(negedge clk);
            while (out_valid !== 1'b1 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (out_valid !== 1'b1) begin
                errors++;
                lost = 1'b1;
                $display("timeout: no output arrived for row %0d", r);
            end else if (exp_res_q.size() == 0) begin
                errors++;
                lost = 1'b1;
                $display("an output arrived while no row was pending");
            end else begin
                exp_res = exp_res_q.pop_front();
                exp_sat = exp_sat_q.pop_front();
                sent    = exp_cyc_q.pop_front();
                check_value($sformatf("latency row %0d", r), cyc - sent, LATENCY);
                for (int l = 0; l < L; l++) begin
                    check_value($sformatf("result[%0d] row %0d", l, r),
                                result[l*N +: N], exp_res[l*N +: N]);
                end
                check_value($sformatf("sat row %0d", r), sat, exp_sat);
            end
        end
        // pipeline should go quiet once drained.
        for (int i = 0; i < 2 * LATENCY; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                errors++;
                $display("out_valid seen after the last row had been received");
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        errors   = 0;
        checks   = 0;
        void'($urandom(44));
        load_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("out_valid", out_valid, 0);
        fork
            drive_rows();
            collect_results();
        join
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/posit_pkg.sv
common/lane_if.sv
hw/operand_scatter.sv
posit_lane/posit_decode.sv
posit_lane/shift_fields.sv
posit_lane/posit_encode.sv
posit_lane/posit_mul_lane.sv
hw/result_gather.sv
hw/posit_mul_array.sv
verification/tb_posit_mul_array.sv

// ==== Bender.yml ====
package:
  name: posit_mul_array

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/posit_pkg.sv
      - common/lane_if.sv
      - hw/operand_scatter.sv
      - posit_lane/posit_decode.sv
      - posit_lane/shift_fields.sv
      - posit_lane/posit_encode.sv
      - posit_lane/posit_mul_lane.sv
      - hw/result_gather.sv
      - hw/posit_mul_array.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_posit_mul_array.sv
